// File: common/pcs_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared definitions for the 10GBASE-R transmit PCS
// widths, XGMII and PCS character codes, sync headers, block types
// scrambler seed, block classes and transmit FSM states
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package pcs_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths and counts
	////////////////////////////////////////////////////////////////////////////
	localparam int LEN_TX_DATA     = 64;
	localparam int LEN_TX_CTRL     = 8;
	localparam int LEN_CODED_BLOCK = 66;
	// fixed by the standard, one byte lane per control bit
	localparam int LANE_COUNT      = 8;

	// xgmii control characters
	localparam logic [7:0] CGMII_START     = 8'hFB;
	localparam logic [7:0] CGMII_TERMINATE = 8'hFD;
	localparam logic [7:0] CGMII_FSIG      = 8'h5C;
	localparam logic [7:0] CGMII_Q         = 8'h9C;
	localparam logic [7:0] CGMII_IDLE      = 8'h07;
	localparam logic [7:0] CGMII_ERROR     = 8'hFE;

	// 7 bit pcs control codes
	localparam logic [6:0] PCS_IDLE  = 7'h00;
	localparam logic [6:0] PCS_ERROR = 7'h1E;
	// o codes of the ordered set block
	localparam logic [3:0] PCS_Q     = 4'h0;
	localparam logic [3:0] PCS_FSIG  = 4'hF;

	// sync headers, never scrambled
	localparam logic [1:0] DATA_SH = 2'b01;
	localparam logic [1:0] CTRL_SH = 2'b10;

	////////////////////////////////////////////////////////////////////////////
	// block type field
	////////////////////////////////////////////////////////////////////////////
	localparam logic [7:0] BTYPE_CTRL  = 8'h1E;
	localparam logic [7:0] BTYPE_S     = 8'h78;
	localparam logic [7:0] BTYPE_ORDER = 8'h4B;
	// terminate Tn, n is the lane of the terminate character
	localparam logic [7:0] BTYPE_T0    = 8'h87;
	localparam logic [7:0] BTYPE_T1    = 8'h99;
	localparam logic [7:0] BTYPE_T2    = 8'hAA;
	localparam logic [7:0] BTYPE_T3    = 8'hB4;
	localparam logic [7:0] BTYPE_T4    = 8'hCC;
	localparam logic [7:0] BTYPE_T5    = 8'hD2;
	localparam logic [7:0] BTYPE_T6    = 8'hE1;
	localparam logic [7:0] BTYPE_T7    = 8'hFF;

	// x^58 + x^39 + 1 state after reset
	localparam logic [57:0] SCRAMBLER_SEED = {58{1'b1}};

	// block class as seen by the transmit FSM
	typedef enum logic [2:0] {BLK_C, BLK_S, BLK_D, BLK_T, BLK_E} block_class_t;

	// transmit FSM states
	typedef enum logic [2:0] {TX_INIT, TX_C, TX_D, TX_T, TX_E} tx_state_t;

endpackage

`default_nettype wire

// File: source/xgmii_capture.sv
////////////////////////////////////////////////////////////////////////////
// xgmii input register
// holds the word between enables, one cycle valid strobe
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module xgmii_capture
(
	input  logic                            i_clock,
	input  logic                            i_reset,
	input  logic                            i_enable,
	input  logic [pcs_pkg::LEN_TX_DATA-1:0] i_tx_data,
	input  logic [pcs_pkg::LEN_TX_CTRL-1:0] i_tx_ctrl,
	output logic [pcs_pkg::LEN_TX_DATA-1:0] o_tx_data,
	output logic [pcs_pkg::LEN_TX_CTRL-1:0] o_tx_ctrl,
	output logic                            o_valid
);

	// control word and strobe
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			// all lanes control, so no data block leaks out of reset
			o_tx_ctrl <= '1;
			o_valid   <= 1'b0;
		end
		else
		begin
			o_valid <= i_enable;
			if (i_enable)
				o_tx_ctrl <= i_tx_ctrl;
		end
	end

	// payload byte lanes
	always_ff @(posedge i_clock)
	begin
		if (i_enable)
			o_tx_data <= i_tx_data;
	end

endmodule

`default_nettype wire

// File: encoder/lane_classifier.sv
////////////////////////////////////////////////////////////////////////////
// byte lane classifier
// xgmii character to 7 bit pcs code plus role flags
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module lane_classifier
(
	input  logic [7:0] i_char,
	input  logic       i_ctrl,
	output logic [6:0] o_pcs_char,
	output logic       o_is_fill,
	output logic       o_is_idle,
	output logic       o_is_start,
	output logic       o_is_term,
	output logic       o_is_ordered,
	output logic [3:0] o_o_code
);

	import pcs_pkg::*;

	always_comb
	begin
		// data lane, or a control character with no role
		o_pcs_char   = PCS_ERROR;
		o_is_fill    = 1'b0;
		o_is_idle    = 1'b0;
		o_is_start   = 1'b0;
		o_is_term    = 1'b0;
		o_is_ordered = 1'b0;
		o_o_code     = PCS_Q;
		if (i_ctrl)
		begin
			case (i_char)
				CGMII_IDLE:
				begin
					o_pcs_char = PCS_IDLE;
					o_is_fill  = 1'b1;
					o_is_idle  = 1'b1;
				end
				// error is legal fill but forces class E on idle blocks
				CGMII_ERROR:
					o_is_fill = 1'b1;
				CGMII_START:
					o_is_start = 1'b1;
				CGMII_TERMINATE:
					o_is_term = 1'b1;
				// sequence and signal ordered sets differ only in o code
				CGMII_Q:
					o_is_ordered = 1'b1;
				CGMII_FSIG:
				begin
					o_is_ordered = 1'b1;
					o_o_code     = PCS_FSIG;
				end
				default:
					o_pcs_char = PCS_ERROR;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: encoder/block_encoder.sv
////////////////////////////////////////////////////////////////////////////
// 64b/66b block encoder
// matches control pattern and lane flags against every block format
// builds the 66 bit block and its class with the error block as default
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module block_encoder
(
	input  logic [pcs_pkg::LEN_TX_DATA-1:0]     i_lane_data,
	input  logic [pcs_pkg::LEN_TX_CTRL-1:0]     i_ctrl,
	input  logic [7*pcs_pkg::LANE_COUNT-1:0]    i_pcs_chars,
	input  logic [pcs_pkg::LANE_COUNT-1:0]      i_is_fill,
	input  logic [pcs_pkg::LANE_COUNT-1:0]      i_is_idle,
	input  logic [pcs_pkg::LANE_COUNT-1:0]      i_is_start,
	input  logic [pcs_pkg::LANE_COUNT-1:0]      i_is_term,
	input  logic [pcs_pkg::LANE_COUNT-1:0]      i_is_ordered,
	input  logic [4*pcs_pkg::LANE_COUNT-1:0]    i_o_code,
	output logic [pcs_pkg::LEN_CODED_BLOCK-1:0] o_tx_coded,
	output pcs_pkg::block_class_t               o_block_class
);

	import pcs_pkg::*;

	// lane k sits at flag bit LANE_COUNT-1-k so lane 0 is the msb
	logic                   is_data_blk;
	logic                   is_fill_blk;
	logic                   is_start_blk;
	logic                   is_ordered_blk;
	logic                   term_hit;
	logic [2:0]             term_lane;
	// payload after the type byte holds lanes 0 to 6 of the data
	logic [LEN_TX_DATA-9:0] data_mask;
	logic [LEN_TX_DATA-9:0] fill_mask;
	logic [LEN_TX_DATA-9:0] term_payload;

	// type byte of terminate Tn
	function automatic logic [7:0] term_btype(input logic [2:0] lane);
		case (lane)
			3'd0:    return BTYPE_T0;
			3'd1:    return BTYPE_T1;
			3'd2:    return BTYPE_T2;
			3'd3:    return BTYPE_T3;
			3'd4:    return BTYPE_T4;
			3'd5:    return BTYPE_T5;
			3'd6:    return BTYPE_T6;
			default: return BTYPE_T7;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// format matching
	////////////////////////////////////////////////////////////////////////////
	assign is_data_blk    = (i_ctrl == 8'h00);
	// every lane idle or error
	assign is_fill_blk    = (i_ctrl == 8'hFF) && (&i_is_fill);
	// only lane 0 is control
	assign is_start_blk   = (i_ctrl == 8'h80) && i_is_start[LANE_COUNT-1];
	assign is_ordered_blk = (i_ctrl == 8'h80) && i_is_ordered[LANE_COUNT-1];

	// Tn has n data lanes, the terminate in lane n and fill in lanes n+1 to 7
	always_comb
	begin
		term_hit  = 1'b0;
		term_lane = 3'd0;
		for (int n = 0; n < LANE_COUNT; n++)
		begin
			if ((i_ctrl == (8'hFF >> n)) && i_is_term[LANE_COUNT-1-n]
				&& (&(i_is_fill | ~(8'hFF >> (n + 1)))))
			begin
				term_hit  = 1'b1;
				term_lane = 3'(n);
			end
		end
	end

	// keep the n data bytes on top and the fill codes at the bottom
	// bits between them are the zero pad
	assign data_mask    = ~({(LEN_TX_DATA-8){1'b1}} >> (8 * term_lane));
	assign fill_mask    = {(LEN_TX_DATA-8){1'b1}} >> (7 * term_lane + 7);
	assign term_payload = (i_lane_data[LEN_TX_DATA-1:8] & data_mask)
		| (i_pcs_chars & fill_mask);

	////////////////////////////////////////////////////////////////////////////
	// block assembly
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		// anything unmatched becomes the error block
		o_tx_coded    = {CTRL_SH, BTYPE_CTRL, {LANE_COUNT{PCS_ERROR}}};
		o_block_class = BLK_E;
		if (is_data_blk)
		begin
			o_tx_coded    = {DATA_SH, i_lane_data};
			o_block_class = BLK_D;
		end
		else if (is_start_blk)
		begin
			o_tx_coded    = {CTRL_SH, BTYPE_S, i_lane_data[LEN_TX_DATA-9:0]};
			o_block_class = BLK_S;
		end
		else if (is_ordered_blk)
		begin
			// lanes 1 to 3, o code of lane 0, then 28 zero bits
			o_tx_coded    = {CTRL_SH, BTYPE_ORDER, i_lane_data[LEN_TX_DATA-9 -: 24],
				i_o_code[4*LANE_COUNT-1 -: 4], 28'd0};
			o_block_class = BLK_C;
		end
		else if (is_fill_blk)
		begin
			o_tx_coded    = {CTRL_SH, BTYPE_CTRL, i_pcs_chars};
			// one error character is enough to make it class E
			o_block_class = (&i_is_idle) ? BLK_C : BLK_E;
		end
		else if (term_hit)
		begin
			o_tx_coded    = {CTRL_SH, term_btype(term_lane), term_payload};
			o_block_class = BLK_T;
		end
		// lane roles are exclusive so at most one block format matches
		assert ($onehot0({is_data_blk, is_fill_blk, is_start_blk, is_ordered_blk,
			term_hit}));
	end

endmodule

`default_nettype wire

// File: encoder/tx_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// transmit FSM of 10GBASE-R
// out of order blocks are replaced by the error block, one cycle latency
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module tx_sequencer
(
	input  logic                                i_clock,
	input  logic                                i_reset,
	input  logic                                i_valid,
	input  logic [pcs_pkg::LEN_CODED_BLOCK-1:0] i_tx_coded,
	input  pcs_pkg::block_class_t               i_block_class,
	output logic                                o_valid,
	output logic [pcs_pkg::LEN_CODED_BLOCK-1:0] o_tx_coded,
	output pcs_pkg::block_class_t               o_block_class
);

	import pcs_pkg::*;

	tx_state_t state;
	tx_state_t state_next;

	////////////////////////////////////////////////////////////////////////////
	// next state by incoming class
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		state_next = TX_E;
		case (state)
			// between packets, control or start only
			TX_INIT, TX_C, TX_T:
				case (i_block_class)
					BLK_C:   state_next = TX_C;
					BLK_S:   state_next = TX_D;
					default: state_next = TX_E;
				endcase
			// inside a packet, data until terminate
			TX_D:
				case (i_block_class)
					BLK_D:   state_next = TX_D;
					BLK_T:   state_next = TX_T;
					default: state_next = TX_E;
				endcase
			// recover on any legal block except start
			TX_E:
				case (i_block_class)
					BLK_D:   state_next = TX_D;
					BLK_T:   state_next = TX_T;
					BLK_C:   state_next = TX_C;
					default: state_next = TX_E;
				endcase
			default:
				state_next = TX_E;
		endcase
	end

	// state only moves on valid blocks
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state   <= TX_INIT;
			o_valid <= 1'b0;
		end
		else
		begin
			o_valid <= i_valid;
			if (i_valid)
				state <= state_next;
		end
	end

	// output block, error block whenever we land in TX_E
	always_ff @(posedge i_clock)
	begin
		if (i_valid)
		begin
			if (state_next == TX_E)
			begin
				o_tx_coded    <= {CTRL_SH, BTYPE_CTRL, {LANE_COUNT{PCS_ERROR}}};
				o_block_class <= BLK_E;
			end
			else
			begin
				o_tx_coded    <= i_tx_coded;
				o_block_class <= i_block_class;
			end
		end
	end

	// a packet only opens from idle through a start block
	assert property (@(posedge i_clock) disable iff (i_reset)
		(state == TX_D && $past(state) == TX_C)
		|-> $past(i_valid && i_block_class == BLK_S));

endmodule

`default_nettype wire

// File: source/scrambler.sv
////////////////////////////////////////////////////////////////////////////
// self synchronizing x^58 + x^39 + 1 payload scrambler
// sync header passes through, result is registered
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module scrambler
(
	input  logic                                i_clock,
	input  logic                                i_reset,
	input  logic                                i_valid,
	input  logic [pcs_pkg::LEN_CODED_BLOCK-1:0] i_tx_coded,
	input  pcs_pkg::block_class_t               i_block_class,
	output logic                                o_valid,
	output logic [pcs_pkg::LEN_CODED_BLOCK-1:0] o_tx_coded,
	output pcs_pkg::block_class_t               o_block_class
);

	import pcs_pkg::*;

	logic [57:0]            lfsr;
	logic [57:0]            lfsr_next;
	logic [LEN_TX_DATA-1:0] scrambled;

	// serial form unrolled, lowest payload bit goes first
	// bit 0 of the state is the most recent scrambled bit
	always_comb
	begin
		logic [57:0] s;
		s = lfsr;
		for (int i = 0; i < LEN_TX_DATA; i++)
		begin
			scrambled[i] = i_tx_coded[i] ^ s[38] ^ s[57];
			s            = {s[56:0], scrambled[i]};
		end
		lfsr_next = s;
	end

	// state advances only on valid blocks
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			lfsr    <= SCRAMBLER_SEED;
			o_valid <= 1'b0;
		end
		else
		begin
			o_valid <= i_valid;
			if (i_valid)
				lfsr <= lfsr_next;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_valid)
		begin
			o_tx_coded    <= {i_tx_coded[LEN_CODED_BLOCK-1 -: 2], scrambled};
			o_block_class <= i_block_class;
		end
	end

	// every block leaving the pcs has a legal sync header
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_valid |-> (o_tx_coded[LEN_CODED_BLOCK-1 -: 2] == DATA_SH
		|| o_tx_coded[LEN_CODED_BLOCK-1 -: 2] == CTRL_SH));

endmodule

`default_nettype wire

// File: source/pcs_tx_top.sv
////////////////////////////////////////////////////////////////////////////
// transmit PCS top level
// capture, eight lane classifiers, encoder, transmit FSM, scrambler
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module pcs_tx_top
(
	input  logic                                i_clock,
	input  logic                                i_reset,
	input  logic                                i_enable,
	input  logic [pcs_pkg::LEN_TX_DATA-1:0]     i_tx_data,
	input  logic [pcs_pkg::LEN_TX_CTRL-1:0]     i_tx_ctrl,
	output logic                                o_valid,
	output logic [pcs_pkg::LEN_CODED_BLOCK-1:0] o_tx_coded,
	output pcs_pkg::block_class_t               o_block_class
);

	import pcs_pkg::*;

	// capture stage
	logic [LEN_TX_DATA-1:0]     cap_data;
	logic [LEN_TX_CTRL-1:0]     cap_ctrl;
	logic                       cap_valid;
	// lane results, lane 0 in the top bits
	logic [7*LANE_COUNT-1:0]    lane_pcs_chars;
	logic [LANE_COUNT-1:0]      lane_is_fill;
	logic [LANE_COUNT-1:0]      lane_is_idle;
	logic [LANE_COUNT-1:0]      lane_is_start;
	logic [LANE_COUNT-1:0]      lane_is_term;
	logic [LANE_COUNT-1:0]      lane_is_ordered;
	logic [4*LANE_COUNT-1:0]    lane_o_codes;
	// encoder and sequencer stages
	logic [LEN_CODED_BLOCK-1:0] enc_coded;
	block_class_t               enc_class;
	logic                       seq_valid;
	logic [LEN_CODED_BLOCK-1:0] seq_coded;
	block_class_t               seq_class;

	xgmii_capture u_capture
	(
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_enable  (i_enable),
		.i_tx_data (i_tx_data),
		.i_tx_ctrl (i_tx_ctrl),
		.o_tx_data (cap_data),
		.o_tx_ctrl (cap_ctrl),
		.o_valid   (cap_valid)
	);

	////////////////////////////////////////////////////////////////////////////
	// one classifier per byte lane
	////////////////////////////////////////////////////////////////////////////
	for (genvar k = 0; k < LANE_COUNT; k++)
	begin : g_lane
		lane_classifier u_lane
		(
			.i_char       (cap_data[LEN_TX_DATA-1-8*k -: 8]),
			.i_ctrl       (cap_ctrl[LANE_COUNT-1-k]),
			.o_pcs_char   (lane_pcs_chars[7*(LANE_COUNT-k)-1 -: 7]),
			.o_is_fill    (lane_is_fill[LANE_COUNT-1-k]),
			.o_is_idle    (lane_is_idle[LANE_COUNT-1-k]),
			.o_is_start   (lane_is_start[LANE_COUNT-1-k]),
			.o_is_term    (lane_is_term[LANE_COUNT-1-k]),
			.o_is_ordered (lane_is_ordered[LANE_COUNT-1-k]),
			.o_o_code     (lane_o_codes[4*(LANE_COUNT-k)-1 -: 4])
		);
	end

	block_encoder u_encoder
	(
		.i_lane_data   (cap_data),
		.i_ctrl        (cap_ctrl),
		.i_pcs_chars   (lane_pcs_chars),
		.i_is_fill     (lane_is_fill),
		.i_is_idle     (lane_is_idle),
		.i_is_start    (lane_is_start),
		.i_is_term     (lane_is_term),
		.i_is_ordered  (lane_is_ordered),
		.i_o_code      (lane_o_codes),
		.o_tx_coded    (enc_coded),
		.o_block_class (enc_class)
	);

	tx_sequencer u_sequencer
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_valid       (cap_valid),
		.i_tx_coded    (enc_coded),
		.i_block_class (enc_class),
		.o_valid       (seq_valid),
		.o_tx_coded    (seq_coded),
		.o_block_class (seq_class)
	);

	scrambler u_scrambler
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_valid       (seq_valid),
		.i_tx_coded    (seq_coded),
		.i_block_class (seq_class),
		.o_valid       (o_valid),
		.o_tx_coded    (o_tx_coded),
		.o_block_class (o_block_class)
	);

endmodule

`default_nettype wire

// File: verif/pcs_tx_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the transmit PCS
// vector file reader, stimulus driver, payload scrambler model
// output monitor with latency check, watchdog
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module pcs_tx_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import pcs_pkg::*;

	localparam int CLOCK_PERIOD = 20;
	localparam int RESET_CYCLES = 5;
	localparam int DRIVE_DELAY  = 2;
	// capture, sequencer and scrambler registers
	localparam int PIPE_STAGES  = 3;
	localparam int MAX_VECTORS  = 64;
	localparam int RANDOM_SEED  = 85320;

	logic                       i_clock;
	logic                       i_reset;
	logic                       i_enable;
	logic [LEN_TX_DATA-1:0]     i_tx_data;
	logic [LEN_TX_CTRL-1:0]     i_tx_ctrl;
	logic                       o_valid;
	logic [LEN_CODED_BLOCK-1:0] o_tx_coded;
	block_class_t               o_block_class;

	// count word, then five words per vector
	logic [71:0]                vec_mem [0:5*MAX_VECTORS];
	int                         vec_count;
	int                         gap_cycles [0:MAX_VECTORS-1];
	int                         watchdog_ns;
	logic                       watchdog_armed = 1'b0;
	int                         edge_count = 0;
	int                         received = 0;
	// scrambler model state with bit 0 the last bit sent
	logic [57:0]                tx_history;

	// expected outputs in input order
	logic [LEN_CODED_BLOCK-1:0] exp_block_q [$];
	block_class_t               exp_class_q [$];
	int                         exp_due_q [$];
	logic [LEN_CODED_BLOCK-1:0] exp_block;
	block_class_t               exp_class;
	int                         exp_due;

	pcs_tx_top UUT
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_enable      (i_enable),
		.i_tx_data     (i_tx_data),
		.i_tx_ctrl     (i_tx_ctrl),
		.o_valid       (o_valid),
		.o_tx_coded    (o_tx_coded),
		.o_block_class (o_block_class)
	);

	task automatic check_value(input string name, input logic [71:0] actual,
		input logic [71:0] expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// x^58 + x^39 + 1 where each sent bit is data xor the bits sent 39 and 58 earlier
	function automatic logic [LEN_TX_DATA-1:0] scramble_payload(
		input logic [LEN_TX_DATA-1:0] payload);
		logic [LEN_TX_DATA-1:0] result;
		logic                   sent;
		for (int i = 0; i < LEN_TX_DATA; i++)
		begin
			sent       = payload[i] ^ tx_history[38] ^ tx_history[57];
			result[i]  = sent;
			tx_history = {tx_history[56:0], sent};
		end
		return result;
	endfunction

	initial
	begin
		i_clock = 1'b0;
		forever
			#(CLOCK_PERIOD / 2) i_clock = ~i_clock;
	end

	always @(posedge i_clock)
	begin
		edge_count <= edge_count + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////
	initial
	begin : driver
		int                         base;
		int                         gap_total;
		logic [LEN_CODED_BLOCK-1:0] block;
		logic [LEN_CODED_BLOCK-1:0] scrambled;
		i_reset    = 1'b1;
		i_enable   = 1'b0;
		i_tx_data  = '0;
		i_tx_ctrl  = '1;
		tx_history = SCRAMBLER_SEED;
		void'($urandom(RANDOM_SEED));
		$readmemh("verif/pcs_tx_testdata.txt", vec_mem);
		vec_count = int'(vec_mem[0][15:0]);
		if (vec_count < 1 || vec_count > MAX_VECTORS)
		begin
			$display("vector file gives a bad vector count of %0d", vec_count);
			$display("Simulation failed");
			$fatal(1);
		end
		gap_total = 0;
		for (int i = 0; i < vec_count; i++)
		begin
			// file gap plus up to two random idle cycles
			gap_cycles[i] = int'(vec_mem[1+5*i][7:0]) + int'($urandom % 3);
			gap_total     = gap_total + gap_cycles[i];
		end
		watchdog_ns    = (vec_count + gap_total + 20) * CLOCK_PERIOD * 2;
		watchdog_armed = 1'b1;

		repeat (RESET_CYCLES) @(posedge i_clock);
		#DRIVE_DELAY;
		i_reset = 1'b0;

		for (int i = 0; i < vec_count; i++)
		begin
			base = 1 + 5 * i;
			repeat (gap_cycles[i])
			begin
				@(posedge i_clock);
				#DRIVE_DELAY;
				i_enable = 1'b0;
			end
			@(posedge i_clock);
			#DRIVE_DELAY;
			i_enable  = 1'b1;
			i_tx_ctrl = vec_mem[base+1][LEN_TX_CTRL-1:0];
			i_tx_data = vec_mem[base+2][LEN_TX_DATA-1:0];
			block     = vec_mem[base+3][LEN_CODED_BLOCK-1:0];
			// sync header goes out in the clear
			scrambled = {block[LEN_CODED_BLOCK-1 -: 2],
				scramble_payload(block[LEN_TX_DATA-1:0])};
			exp_block_q.push_back(scrambled);
			exp_class_q.push_back(block_class_t'(vec_mem[base+4][2:0]));
			// sampled on the next edge and out after the third register
			exp_due_q.push_back(edge_count + PIPE_STAGES);
		end
		@(posedge i_clock);
		#DRIVE_DELAY;
		i_enable = 1'b0;

		wait (received == vec_count);
		// room for a stray extra block to show up
		repeat (PIPE_STAGES + 2) @(posedge i_clock);
		$display("Simulation completed successfully");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// output monitor sampled mid cycle
	////////////////////////////////////////////////////////////////////////////
	always @(negedge i_clock)
	begin
		if (o_valid === 1'b1)
		begin
			if (exp_block_q.size() == 0)
			begin
				$display("o_valid came high with no block pending");
				$display("Simulation failed");
				$fatal(1);
			end
			else
			begin
				exp_block = exp_block_q.pop_front();
				exp_class = exp_class_q.pop_front();
				exp_due   = exp_due_q.pop_front();
				check_value("o_valid edge", 72'(edge_count), 72'(exp_due));
				check_value("o_tx_coded", 72'(o_tx_coded), 72'(exp_block));
				check_value("o_block_class", 72'(o_block_class), 72'(exp_class));
				received = received + 1;
			end
		end
	end

	initial
	begin : watchdog
		wait (watchdog_armed);
		#(watchdog_ns);
		$display("watchdog expired with %0d of %0d blocks out", received, vec_count);
		$display("Simulation failed");
		$fatal(1);
	end

endmodule

`default_nettype wire

// File: verif/pcs_tx_testdata.txt
// first word: vector count; then per line: enable gap, xgmii ctrl, xgmii data (lane 0 first),
// expected unscrambled block (sync header on top), expected class (0 C, 1 S, 2 D, 3 T, 4 E)
28
0 FF 0707070707070707 21E00000000000000 0
1 80 9C11223344556677 24B11223300000000 0
0 80 5CAABBCCDDEEFF00 24BAABBCCF0000000 0
2 80 FB555555555555D5 278555555555555D5 1
0 00 0123456789ABCDEF 10123456789ABCDEF 2
0 1F A1A2A3FD07070707 2B4A1A2A300000000 3
0 FF 0707070707070707 21E00000000000000 0
1 80 FB555555555555D5 278555555555555D5 1
0 FF FD07FE0707070707 2870000F000000000 3
0 80 FB555555555555D5 278555555555555D5 1
0 7F D1FDFEFE07070707 299D100F1E0000000 3
1 80 FB555555555555D5 278555555555555D5 1
0 3F D1D2FD07070707FE 2AAD1D2000000001E 3
0 80 FB555555555555D5 278555555555555D5 1
0 0F D1D2D3D4FDFEFEFE 2CCD1D2D3D4078F1E 3
0 80 FB555555555555D5 278555555555555D5 1
2 07 D1D2D3D4D5FD07FE 2D2D1D2D3D4D5001E 3
0 80 FB555555555555D5 278555555555555D5 1
0 03 D1D2D3D4D5D6FDFE 2E1D1D2D3D4D5D61E 3
0 80 FB555555555555D5 278555555555555D5 1
1 01 D1D2D3D4D5D6D7FD 2FFD1D2D3D4D5D6D7 3
0 FF 0707070707070707 21E00000000000000 0
0 40 0007000000000000 21E3C78F1E3C78F1E 4
0 FF 0707070707070707 21E00000000000000 0
1 FF 070707AB07070707 21E3C78F1E3C78F1E 4
0 FF 0707070707070707 21E00000000000000 0
0 80 FB555555555555D5 278555555555555D5 1
0 1B A1A2A3FD0707A507 21E3C78F1E3C78F1E 4
0 00 1111111111111111 11111111111111111 2
0 01 D1D2D3D4D5D6D7FD 2FFD1D2D3D4D5D6D7 3
0 FF 0707070707070707 21E00000000000000 0
0 00 2222222222222222 21E3C78F1E3C78F1E 4
0 FF 0707070707070707 21E00000000000000 0
0 80 FB555555555555D5 278555555555555D5 1
0 80 FB555555555555D5 21E3C78F1E3C78F1E 4
0 00 3333333333333333 13333333333333333 2
0 FF 0707070707070707 21E3C78F1E3C78F1E 4
0 FF 0707070707070707 21E00000000000000 0
0 FF 07FE070707070707 21E3C78F1E3C78F1E 4
0 FF 0707070707070707 21E00000000000000 0

// File: sim.f
common/pcs_pkg.sv
source/xgmii_capture.sv
encoder/lane_classifier.sv
encoder/block_encoder.sv
encoder/tx_sequencer.sv
source/scrambler.sv
source/pcs_tx_top.sv
verif/pcs_tx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the transmit PCS testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

# build the testbench and the DUT into obj_dir
if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module pcs_tx_tb -f sim.f --Mdir obj_dir -o pcs_tx_sim; then
	echo "verilator build failed"
	exit 1
fi

# a failing check ends the run with a nonzero status
if ! ./obj_dir/pcs_tx_sim; then
	echo "simulation run returned a failing status"
	exit 1
fi

echo "simulation run returned status 0"
exit 0
